// File: design/mfb_splitter_pkg.sv
// -------------------
// Shared sizes and register map of the MFB frame splitter
// Referenced by scoped name from the RTL and the testbench
// -------------------

package mfb_splitter_pkg;

    // Transmit port count and the select field that picks one
    localparam int OUTPUTS = 4;
    localparam int SEL_W   = $clog2(OUTPUTS);

    // Beat payload
    localparam int DATA_W = 64;

    // Metadata as forwarded on TX
    localparam int META_W = 8;

    // Metadata as received, select sits in the low SEL_W bits
    localparam int RX_META_W = SEL_W + META_W;

    // Statistics counters
    localparam int CNT_W = 16;

    // Wishbone statistics port
    localparam int WB_ADR_W = 3;
    localparam int WB_DAT_W = 32;

    // Register map
    // Addresses 0 .. OUTPUTS-1 hold the per-port frame counters
    localparam logic [WB_ADR_W-1:0] ADR_DROPS = 3'd4;

endpackage

// File: design/mfb_rx_skid.sv
// -------------------
// Two-entry receive skid buffer on the MFB RX port
// Registered rx_dst_rdy at one beat per cycle
// -------------------
`timescale 1ns/1ps

module mfb_rx_skid (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [mfb_splitter_pkg::DATA_W-1:0]    rx_data,
    input  logic [mfb_splitter_pkg::RX_META_W-1:0] rx_meta,
    input  logic                                   rx_sof,
    input  logic                                   rx_eof,
    input  logic                                   rx_src_rdy,
    output logic                                   rx_dst_rdy,
    output logic [mfb_splitter_pkg::DATA_W-1:0]    buf_data,
    output logic [mfb_splitter_pkg::RX_META_W-1:0] buf_meta,
    output logic                                   buf_sof,
    output logic                                   buf_eof,
    output logic                                   buf_valid,
    input  logic                                   buf_take
);

    // Holding register, catches the beat accepted while the main one stalls
    logic [mfb_splitter_pkg::DATA_W-1:0]    hold_data;
    logic [mfb_splitter_pkg::RX_META_W-1:0] hold_meta;
    logic                                   hold_sof;
    logic                                   hold_eof;
    logic                                   hold_valid;

    logic ready_q;
    logic rx_xfer;
    logic main_free;

    assign rx_dst_rdy = ready_q;
    assign rx_xfer    = rx_src_rdy && ready_q;
    // Main register is empty or drained this cycle
    assign main_free  = !buf_valid || buf_take;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_valid  <= 1'b0;
            hold_valid <= 1'b0;
            ready_q    <= 1'b0;
        end else if (main_free) begin
            // Hold entry drains first, ready is never high with hold full
            buf_valid  <= hold_valid || rx_xfer;
            hold_valid <= 1'b0;
            ready_q    <= 1'b1;
        end else if (rx_xfer) begin
            // Last beat in flight lands in the hold entry
            hold_valid <= 1'b1;
            ready_q    <= 1'b0;
        end else begin
            ready_q <= !hold_valid;
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        if (main_free) begin
            if (hold_valid) begin
                buf_data <= hold_data;
                buf_meta <= hold_meta;
                buf_sof  <= hold_sof;
                buf_eof  <= hold_eof;
            end else if (rx_xfer) begin
                buf_data <= rx_data;
                buf_meta <= rx_meta;
                buf_sof  <= rx_sof;
                buf_eof  <= rx_eof;
            end
        end else if (rx_xfer) begin
            hold_data <= rx_data;
            hold_meta <= rx_meta;
            hold_sof  <= rx_sof;
            hold_eof  <= rx_eof;
        end
    end

    // Stalled beat must not change under the consumer
    a_buf_stable: assert property (@(posedge clk) disable iff (!rst_n)
        buf_valid && !buf_take |=> buf_valid && $stable(buf_data) && $stable(buf_meta)
            && $stable(buf_sof) && $stable(buf_eof));

endmodule

// File: design/splitter_ctrl.sv
// -------------------
// Frame control, picks the output at SOF
// Forwards in-frame beats and drops orphan beats
// -------------------
`timescale 1ns/1ps

module splitter_ctrl (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [mfb_splitter_pkg::RX_META_W-1:0] buf_meta,
    input  logic                                   buf_sof,
    input  logic                                   buf_eof,
    input  logic                                   buf_valid,
    output logic                                   buf_take,
    output logic                                   fwd_valid,
    output logic [mfb_splitter_pkg::SEL_W-1:0]     fwd_sel,
    input  logic                                   fwd_ready,
    output logic                                   drop_pulse
);

    logic                               in_frame;
    logic [mfb_splitter_pkg::SEL_W-1:0] sel_q;
    logic [mfb_splitter_pkg::SEL_W-1:0] sof_sel;
    logic                               fwd_accept;

    // Select rides in the low metadata bits
    assign sof_sel = buf_meta[mfb_splitter_pkg::SEL_W-1:0];

    // SOF always opens a frame, even mid-frame
    assign fwd_valid  = buf_valid && (buf_sof || in_frame);
    assign fwd_sel    = buf_sof ? sof_sel : sel_q;
    assign fwd_accept = fwd_valid && fwd_ready;

    // Beat outside any frame
    assign drop_pulse = buf_valid && !buf_sof && !in_frame;

    // Drops never wait on the demux
    assign buf_take = fwd_accept || drop_pulse;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_frame <= 1'b0;
            sel_q    <= '0;
        end else if (fwd_accept) begin
            // Single-beat frame leaves us idle
            in_frame <= !buf_eof;
            if (buf_sof) begin
                sel_q <= sof_sel;
            end
        end
    end

    // A beat is either forwarded or dropped, never both
    a_fwd_drop_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(fwd_valid && drop_pulse));

endmodule

// File: design/mfb_tx_demux.sv
// -------------------
// TX output register stage
// Strips the select and shows the beat on the chosen port only
// -------------------
`timescale 1ns/1ps

module mfb_tx_demux (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [mfb_splitter_pkg::DATA_W-1:0]    buf_data,
    input  logic [mfb_splitter_pkg::RX_META_W-1:0] buf_meta,
    input  logic                                   buf_sof,
    input  logic                                   buf_eof,
    input  logic                                   fwd_valid,
    input  logic [mfb_splitter_pkg::SEL_W-1:0]     fwd_sel,
    output logic                                   fwd_ready,
    output logic [mfb_splitter_pkg::DATA_W-1:0]    tx_data [mfb_splitter_pkg::OUTPUTS],
    output logic [mfb_splitter_pkg::META_W-1:0]    tx_meta [mfb_splitter_pkg::OUTPUTS],
    output logic [mfb_splitter_pkg::OUTPUTS-1:0]   tx_sof,
    output logic [mfb_splitter_pkg::OUTPUTS-1:0]   tx_eof,
    output logic [mfb_splitter_pkg::OUTPUTS-1:0]   tx_src_rdy,
    input  logic [mfb_splitter_pkg::OUTPUTS-1:0]   tx_dst_rdy
);

    logic [mfb_splitter_pkg::DATA_W-1:0] data_q;
    logic [mfb_splitter_pkg::META_W-1:0] meta_q;
    logic                                sof_q;
    logic                                eof_q;
    logic [mfb_splitter_pkg::SEL_W-1:0]  port_q;
    logic                                valid_q;
    logic                                out_xfer;

    // Handshake on the target port only
    assign out_xfer  = valid_q && tx_dst_rdy[port_q];
    // Load when empty or emptying
    assign fwd_ready = !valid_q || out_xfer;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (fwd_ready) begin
            valid_q <= fwd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fwd_ready && fwd_valid) begin
            data_q <= buf_data;
            // Drop the select bits
            meta_q <= buf_meta[mfb_splitter_pkg::RX_META_W-1:mfb_splitter_pkg::SEL_W];
            sof_q  <= buf_sof;
            eof_q  <= buf_eof;
            port_q <= fwd_sel;
        end
    end

    // Same payload on every port, qualified by its own src_rdy
    always_comb begin
        for (int i = 0; i < mfb_splitter_pkg::OUTPUTS; i++) begin
            tx_data[i] = data_q;
            tx_meta[i] = meta_q;
        end
        tx_sof             = {mfb_splitter_pkg::OUTPUTS{sof_q}};
        tx_eof             = {mfb_splitter_pkg::OUTPUTS{eof_q}};
        tx_src_rdy         = '0;
        tx_src_rdy[port_q] = valid_q;
    end

    // At most one port offers a beat
    a_src_rdy_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(tx_src_rdy));

endmodule

// File: design/splitter_stats.sv
// -------------------
// Frame and drop counters behind a Wishbone classic slave
// Reads return a counter, any write clears them all
// -------------------
`timescale 1ns/1ps

module splitter_stats (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [mfb_splitter_pkg::OUTPUTS-1:0]   tx_eof,
    input  logic [mfb_splitter_pkg::OUTPUTS-1:0]   tx_src_rdy,
    input  logic [mfb_splitter_pkg::OUTPUTS-1:0]   tx_dst_rdy,
    input  logic                                   drop_pulse,
    input  logic                                   wb_cyc,
    input  logic                                   wb_stb,
    input  logic                                   wb_we,
    input  logic [mfb_splitter_pkg::WB_ADR_W-1:0]  wb_adr,
    input  logic [mfb_splitter_pkg::WB_DAT_W-1:0]  wb_dat_w,
    output logic [mfb_splitter_pkg::WB_DAT_W-1:0]  wb_dat_r,
    output logic                                   wb_ack
);

    logic [mfb_splitter_pkg::CNT_W-1:0]   frame_cnt [mfb_splitter_pkg::OUTPUTS];
    logic [mfb_splitter_pkg::CNT_W-1:0]   drop_cnt;
    logic [mfb_splitter_pkg::CNT_W-1:0]   rd_val;
    logic [mfb_splitter_pkg::OUTPUTS-1:0] eof_xfer;
    logic                                 wb_req;
    logic                                 cnt_clear;

    // New request only while no ack is out
    assign wb_req    = wb_cyc && wb_stb && !wb_ack;
    // Any write clears, whatever its data
    assign cnt_clear = wb_req && wb_we;

    // Frame ends on its EOF handshake
    assign eof_xfer = tx_eof & tx_src_rdy & tx_dst_rdy;

    always_ff @(posedge clk) begin
        if (!rst_n || cnt_clear) begin
            for (int i = 0; i < mfb_splitter_pkg::OUTPUTS; i++) begin
                frame_cnt[i] <= '0;
            end
            drop_cnt <= '0;
        end else begin
            // Saturate at all ones
            for (int i = 0; i < mfb_splitter_pkg::OUTPUTS; i++) begin
                if (eof_xfer[i] && frame_cnt[i] != '1) begin
                    frame_cnt[i] <= frame_cnt[i] + 1'b1;
                end
            end
            if (drop_pulse && drop_cnt != '1) begin
                drop_cnt <= drop_cnt + 1'b1;
            end
        end
    end

    // Read mux, unmapped addresses give zero
    always_comb begin
        rd_val = '0;
        if (wb_adr < mfb_splitter_pkg::OUTPUTS) begin
            rd_val = frame_cnt[wb_adr[mfb_splitter_pkg::SEL_W-1:0]];
        end else if (wb_adr == mfb_splitter_pkg::ADR_DROPS) begin
            rd_val = drop_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    // Read data lands with the ack
    always_ff @(posedge clk) begin
        if (wb_req && !wb_we) begin
            wb_dat_r <= {{(mfb_splitter_pkg::WB_DAT_W - mfb_splitter_pkg::CNT_W){1'b0}}, rd_val};
        end
    end

    // Single-cycle ack per access
    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack);

endmodule

// File: design/mfb_splitter.sv
// -------------------
// MFB frame splitter top, one RX port to four TX ports
// Wishbone statistics port on the side
// -------------------
`timescale 1ns/1ps

module mfb_splitter (
    input  logic                                   clk,
    input  logic                                   rst_n,
    // RX port
    input  logic [mfb_splitter_pkg::DATA_W-1:0]    rx_data,
    input  logic [mfb_splitter_pkg::RX_META_W-1:0] rx_meta,
    input  logic                                   rx_sof,
    input  logic                                   rx_eof,
    input  logic                                   rx_src_rdy,
    output logic                                   rx_dst_rdy,
    // TX ports
    output logic [mfb_splitter_pkg::DATA_W-1:0]    tx_data [mfb_splitter_pkg::OUTPUTS],
    output logic [mfb_splitter_pkg::META_W-1:0]    tx_meta [mfb_splitter_pkg::OUTPUTS],
    output logic [mfb_splitter_pkg::OUTPUTS-1:0]   tx_sof,
    output logic [mfb_splitter_pkg::OUTPUTS-1:0]   tx_eof,
    output logic [mfb_splitter_pkg::OUTPUTS-1:0]   tx_src_rdy,
    input  logic [mfb_splitter_pkg::OUTPUTS-1:0]   tx_dst_rdy,
    // Wishbone statistics
    input  logic                                   wb_cyc,
    input  logic                                   wb_stb,
    input  logic                                   wb_we,
    input  logic [mfb_splitter_pkg::WB_ADR_W-1:0]  wb_adr,
    input  logic [mfb_splitter_pkg::WB_DAT_W-1:0]  wb_dat_w,
    output logic [mfb_splitter_pkg::WB_DAT_W-1:0]  wb_dat_r,
    output logic                                   wb_ack
);

    // Skid buffer output
    logic [mfb_splitter_pkg::DATA_W-1:0]    buf_data;
    logic [mfb_splitter_pkg::RX_META_W-1:0] buf_meta;
    logic                                   buf_sof;
    logic                                   buf_eof;
    logic                                   buf_valid;
    logic                                   buf_take;

    // Control to demux
    logic                                   fwd_valid;
    logic [mfb_splitter_pkg::SEL_W-1:0]     fwd_sel;
    logic                                   fwd_ready;
    logic                                   drop_pulse;

    mfb_rx_skid u_skid (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_data    (rx_data),
        .rx_meta    (rx_meta),
        .rx_sof     (rx_sof),
        .rx_eof     (rx_eof),
        .rx_src_rdy (rx_src_rdy),
        .rx_dst_rdy (rx_dst_rdy),
        .buf_data   (buf_data),
        .buf_meta   (buf_meta),
        .buf_sof    (buf_sof),
        .buf_eof    (buf_eof),
        .buf_valid  (buf_valid),
        .buf_take   (buf_take)
    );

    splitter_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .buf_meta   (buf_meta),
        .buf_sof    (buf_sof),
        .buf_eof    (buf_eof),
        .buf_valid  (buf_valid),
        .buf_take   (buf_take),
        .fwd_valid  (fwd_valid),
        .fwd_sel    (fwd_sel),
        .fwd_ready  (fwd_ready),
        .drop_pulse (drop_pulse)
    );

    mfb_tx_demux u_demux (
        .clk        (clk),
        .rst_n      (rst_n),
        .buf_data   (buf_data),
        .buf_meta   (buf_meta),
        .buf_sof    (buf_sof),
        .buf_eof    (buf_eof),
        .fwd_valid  (fwd_valid),
        .fwd_sel    (fwd_sel),
        .fwd_ready  (fwd_ready),
        .tx_data    (tx_data),
        .tx_meta    (tx_meta),
        .tx_sof     (tx_sof),
        .tx_eof     (tx_eof),
        .tx_src_rdy (tx_src_rdy),
        .tx_dst_rdy (tx_dst_rdy)
    );

    // Counts frames off the top-level TX handshakes
    splitter_stats u_stats (
        .clk        (clk),
        .rst_n      (rst_n),
        .tx_eof     (tx_eof),
        .tx_src_rdy (tx_src_rdy),
        .tx_dst_rdy (tx_dst_rdy),
        .drop_pulse (drop_pulse),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack)
    );

endmodule

// File: test/tb_mfb_splitter.sv
// --------------------
// Testbench for the MFB frame splitter
// LFSR frames are checked against a reference model, and the counters are read over Wishbone
// --------------------
`timescale 1ns/1ps

module tb_mfb_splitter;

    // Run length
    localparam int ROUTE_FRAMES = 40;
    localparam int BP_FRAMES    = 40;
    localparam int MAX_LEN      = 8;
    localparam int ORPHANS      = 12;
    localparam int WB_OPS       = 12;
    // A Wishbone access costs about three cycles
    localparam int STIM_BEATS = (ROUTE_FRAMES + BP_FRAMES) * MAX_LEN + ORPHANS + 3 * WB_OPS;
    localparam int MAX_CYCLES = 4 * STIM_BEATS + 200;
    // Skid plus demux depth, with margin
    localparam int SETTLE     = 4;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    // Expected beat packed as {data, meta, sof, eof}
    localparam int BEAT_W = mfb_splitter_pkg::DATA_W + mfb_splitter_pkg::META_W + 2;

    logic                                   clk;
    logic                                   rst_n;
    logic [mfb_splitter_pkg::DATA_W-1:0]    rx_data;
    logic [mfb_splitter_pkg::RX_META_W-1:0] rx_meta;
    logic                                   rx_sof;
    logic                                   rx_eof;
    logic                                   rx_src_rdy;
    logic                                   rx_dst_rdy;
    logic [mfb_splitter_pkg::DATA_W-1:0]    tx_data [mfb_splitter_pkg::OUTPUTS];
    logic [mfb_splitter_pkg::META_W-1:0]    tx_meta [mfb_splitter_pkg::OUTPUTS];
    logic [mfb_splitter_pkg::OUTPUTS-1:0]   tx_sof;
    logic [mfb_splitter_pkg::OUTPUTS-1:0]   tx_eof;
    logic [mfb_splitter_pkg::OUTPUTS-1:0]   tx_src_rdy;
    logic [mfb_splitter_pkg::OUTPUTS-1:0]   tx_dst_rdy;
    logic                                   wb_cyc;
    logic                                   wb_stb;
    logic                                   wb_we;
    logic [mfb_splitter_pkg::WB_ADR_W-1:0]  wb_adr;
    logic [mfb_splitter_pkg::WB_DAT_W-1:0]  wb_dat_w;
    logic [mfb_splitter_pkg::WB_DAT_W-1:0]  wb_dat_r;
    logic                                   wb_ack;

    // Reference model state
    logic [BEAT_W-1:0]                  exp_q [mfb_splitter_pkg::OUTPUTS][$];
    logic [mfb_splitter_pkg::CNT_W-1:0] exp_frames [mfb_splitter_pkg::OUTPUTS];
    logic [mfb_splitter_pkg::CNT_W-1:0] exp_drops;
    logic                               model_in_frame;
    logic [mfb_splitter_pkg::SEL_W-1:0] model_sel;
    logic [mfb_splitter_pkg::META_W-1:0] model_meta;
    int                                 rx_port;
    logic [BEAT_W-1:0]                  head;

    logic [31:0] lfsr;
    logic [63:0] bp_bits;
    logic        bp_on;
    string       test_name;
    int          tests;
    int          checks;
    int          errors;
    int          test_checks;
    int          test_errors;
    int          cycles;

    mfb_splitter u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_data    (rx_data),
        .rx_meta    (rx_meta),
        .rx_sof     (rx_sof),
        .rx_eof     (rx_eof),
        .rx_src_rdy (rx_src_rdy),
        .rx_dst_rdy (rx_dst_rdy),
        .tx_data    (tx_data),
        .tx_meta    (tx_meta),
        .tx_sof     (tx_sof),
        .tx_eof     (tx_eof),
        .tx_src_rdy (tx_src_rdy),
        .tx_dst_rdy (tx_dst_rdy),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack)
    );

    always #2 clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [63:0] next_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Expected route of one received beat, -1 for a drop
    function automatic int ref_route(
        input  logic [mfb_splitter_pkg::RX_META_W-1:0] meta,
        input  logic                                   sof,
        input  logic                                   eof,
        inout  logic                                   in_frame,
        inout  logic [mfb_splitter_pkg::SEL_W-1:0]     sel,
        output logic [mfb_splitter_pkg::META_W-1:0]    out_meta
    );
        int port;
        // Select bits never leave the splitter
        out_meta = meta[mfb_splitter_pkg::RX_META_W-1:mfb_splitter_pkg::SEL_W];
        if (sof) begin
            sel      = meta[mfb_splitter_pkg::SEL_W-1:0];
            port     = int'(sel);
            in_frame = !eof;
        end else if (in_frame) begin
            port     = int'(sel);
            in_frame = !eof;
        end else begin
            port = -1;
        end
        return port;
    endfunction

    function automatic int queued_beats();
        int n;
        n = 0;
        for (int p = 0; p < mfb_splitter_pkg::OUTPUTS; p++) begin
            n += exp_q[p].size();
        end
        return n;
    endfunction

    task automatic compare_beat(
        input string                               name,
        input logic [mfb_splitter_pkg::DATA_W-1:0] exp_data,
        input logic [mfb_splitter_pkg::META_W-1:0] exp_meta,
        input logic                                exp_sof,
        input logic                                exp_eof,
        input logic [mfb_splitter_pkg::DATA_W-1:0] act_data,
        input logic [mfb_splitter_pkg::META_W-1:0] act_meta,
        input logic                                act_sof,
        input logic                                act_eof
    );
        checks++;
        if ({exp_data, exp_meta, exp_sof, exp_eof} !== {act_data, act_meta, act_sof, act_eof}) begin
            errors++;
            $display("MISMATCH %s expected %h/%h/%b%b actual %h/%h/%b%b", name,
                exp_data, exp_meta, exp_sof, exp_eof, act_data, act_meta, act_sof, act_eof);
        end
    endtask

    task automatic compare_count(
        input string                              name,
        input logic [mfb_splitter_pkg::CNT_W-1:0] exp_cnt,
        input logic [mfb_splitter_pkg::CNT_W-1:0] act_cnt
    );
        checks++;
        if (exp_cnt !== act_cnt) begin
            errors++;
            $display("MISMATCH %s expected %0d actual %0d", name, exp_cnt, act_cnt);
        end
    endtask

    task automatic compare_flag(input string name, input logic exp_bit, input logic act_bit);
        checks++;
        if (exp_bit !== act_bit) begin
            errors++;
            $display("MISMATCH %s expected %b actual %b", name, exp_bit, act_bit);
        end
    endtask

    // Model sees each beat at the negedge before its RX transfer edge
    always @(negedge clk) begin
        if (rst_n && rx_src_rdy && rx_dst_rdy) begin
            rx_port = ref_route(rx_meta, rx_sof, rx_eof, model_in_frame, model_sel, model_meta);
            if (rx_port < 0) begin
                exp_drops = exp_drops + 1'b1;
            end else begin
                exp_q[rx_port].push_back({rx_data, model_meta, rx_sof, rx_eof});
                if (rx_eof) begin
                    exp_frames[rx_port] = exp_frames[rx_port] + 1'b1;
                end
            end
        end
    end

    // TX monitor
    always @(negedge clk) begin
        for (int p = 0; p < mfb_splitter_pkg::OUTPUTS; p++) begin
            if (rst_n && tx_src_rdy[p] && tx_dst_rdy[p]) begin
                if (exp_q[p].size() == 0) begin
                    errors++;
                    $display("ERROR %s: beat on TX port %0d with nothing expected", test_name, p);
                end else begin
                    head = exp_q[p].pop_front();
                    compare_beat($sformatf("%s port %0d", test_name, p),
                        head[BEAT_W-1 -: mfb_splitter_pkg::DATA_W],
                        head[mfb_splitter_pkg::META_W+1:2], head[1], head[0],
                        tx_data[p], tx_meta[p], tx_sof[p], tx_eof[p]);
                end
            end
        end
    end

    // Per-port back-pressure, random or always ready
    // Bits are drawn on the edge itself, apart from the stimulus draws
    always @(posedge clk) begin
        if (bp_on) begin
            bp_bits = next_bits(mfb_splitter_pkg::OUTPUTS);
        end else begin
            bp_bits = '1;
        end
        #1;
        tx_dst_rdy = bp_bits[mfb_splitter_pkg::OUTPUTS-1:0];
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles in test %s", cycles, test_name);
            $display("sim failed");
            $finish;
        end
    end

    // Called just after a rising edge, returns just after the transfer edge
    task automatic send_beat(
        input logic [mfb_splitter_pkg::DATA_W-1:0]    data,
        input logic [mfb_splitter_pkg::RX_META_W-1:0] meta,
        input logic                                   sof,
        input logic                                   eof
    );
        rx_data    = data;
        rx_meta    = meta;
        rx_sof     = sof;
        rx_eof     = eof;
        rx_src_rdy = 1'b1;
        do begin
            @(negedge clk);
        end while (!rx_dst_rdy);
        @(posedge clk);
        #1;
        rx_src_rdy = 1'b0;
    endtask

    task automatic send_random_frame();
        logic [63:0] r;
        logic [63:0] m;
        int          len;
        r   = next_bits(3);
        len = int'(r[2:0]) + 1;
        for (int b = 0; b < len; b++) begin
            r = next_bits(mfb_splitter_pkg::DATA_W);
            // Low meta bits of later beats are junk the splitter must ignore
            m = next_bits(mfb_splitter_pkg::RX_META_W);
            send_beat(r[mfb_splitter_pkg::DATA_W-1:0], m[mfb_splitter_pkg::RX_META_W-1:0],
                b == 0, b == len - 1);
        end
    endtask

    task automatic drain();
        while (queued_beats() != 0) begin
            @(negedge clk);
        end
        repeat (SETTLE) @(posedge clk);
        #1;
    endtask

    task automatic wb_access(
        input  logic                                 we,
        input  int                                   adr,
        output logic [mfb_splitter_pkg::WB_DAT_W-1:0] rdata
    );
        logic [63:0] r;
        int          waits;
        r        = next_bits(mfb_splitter_pkg::WB_DAT_W);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr[mfb_splitter_pkg::WB_ADR_W-1:0];
        wb_dat_w = we ? r[mfb_splitter_pkg::WB_DAT_W-1:0] : '0;
        // Count edges from the request until ack shows
        waits    = 0;
        do begin
            @(posedge clk);
            waits++;
            @(negedge clk);
        end while (!wb_ack);
        rdata = wb_dat_r;
        if (waits != 1) begin
            errors++;
            $display("ERROR %s: wb_ack came after %0d cycles, not one", test_name, waits);
        end
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        // Ack must already be gone
        @(negedge clk);
        compare_flag({test_name, " wb_ack second cycle"}, 1'b0, wb_ack);
        @(posedge clk);
        #1;
    endtask

    task automatic read_count(input int adr, input logic [mfb_splitter_pkg::CNT_W-1:0] exp_cnt);
        logic [mfb_splitter_pkg::WB_DAT_W-1:0] rdata;
        wb_access(1'b0, adr, rdata);
        compare_count($sformatf("%s adr %0d", test_name, adr), exp_cnt,
            rdata[mfb_splitter_pkg::CNT_W-1:0]);
        checks++;
        if (rdata[mfb_splitter_pkg::WB_DAT_W-1:mfb_splitter_pkg::CNT_W] != '0) begin
            errors++;
            $display("MISMATCH %s adr %0d upper bits expected 0 actual %h", test_name, adr,
                rdata[mfb_splitter_pkg::WB_DAT_W-1:mfb_splitter_pkg::CNT_W]);
        end
    endtask

    task automatic check_reset_outputs();
        compare_flag("reset rx_dst_rdy", 1'b0, rx_dst_rdy);
        compare_flag("reset tx_src_rdy", 1'b0, |tx_src_rdy);
        compare_flag("reset wb_ack", 1'b0, wb_ack);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s done, %0d checks, %0d errors", test_name,
            checks - test_checks, errors - test_errors);
    endtask

    initial begin
        logic [63:0]                           r;
        logic [63:0]                           m;
        logic [mfb_splitter_pkg::WB_DAT_W-1:0] wb_rd;
        clk            = 1'b0;
        rst_n          = 1'b0;
        rx_data        = '0;
        rx_meta        = '0;
        rx_sof         = 1'b0;
        rx_eof         = 1'b0;
        rx_src_rdy     = 1'b0;
        tx_dst_rdy     = '1;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_dat_w       = '0;
        lfsr           = 32'h520e;
        bp_on          = 1'b0;
        model_in_frame = 1'b0;
        model_sel      = '0;
        exp_drops      = '0;
        for (int p = 0; p < mfb_splitter_pkg::OUTPUTS; p++) begin
            exp_frames[p] = '0;
        end
        tests  = 0;
        checks = 0;
        errors = 0;
        cycles = 0;

        // Outputs low through reset and on the first cycle after it
        start_test("reset");
        repeat (3) begin
            @(posedge clk);
            #1;
            check_reset_outputs();
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_reset_outputs();
        @(posedge clk);
        #1;
        end_test();

        start_test("routing");
        repeat (ROUTE_FRAMES) send_random_frame();
        drain();
        end_test();

        start_test("backpressure");
        bp_on = 1'b1;
        repeat (BP_FRAMES) send_random_frame();
        drain();
        bp_on = 1'b0;
        end_test();

        // Idle after the last EOF, so none of these has a frame
        start_test("orphans");
        repeat (ORPHANS) begin
            r = next_bits(mfb_splitter_pkg::DATA_W);
            m = next_bits(mfb_splitter_pkg::RX_META_W + 1);
            send_beat(r[mfb_splitter_pkg::DATA_W-1:0],
                m[mfb_splitter_pkg::RX_META_W-1:0], 1'b0, m[mfb_splitter_pkg::RX_META_W]);
        end
        drain();
        read_count(int'(mfb_splitter_pkg::ADR_DROPS), exp_drops);
        end_test();

        start_test("frame_stats");
        for (int p = 0; p < mfb_splitter_pkg::OUTPUTS; p++) begin
            read_count(p, exp_frames[p]);
        end
        // Unmapped
        read_count(5, '0);
        end_test();

        start_test("counter_clear");
        wb_access(1'b1, 2, wb_rd);
        exp_drops = '0;
        for (int p = 0; p < mfb_splitter_pkg::OUTPUTS; p++) begin
            exp_frames[p] = '0;
        end
        for (int a = 0; a < mfb_splitter_pkg::OUTPUTS; a++) begin
            read_count(a, exp_frames[a]);
        end
        read_count(int'(mfb_splitter_pkg::ADR_DROPS), exp_drops);
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: mfb_splitter.f
design/mfb_splitter_pkg.sv
design/mfb_rx_skid.sv
design/splitter_ctrl.sv
design/mfb_tx_demux.sv
design/splitter_stats.sv
design/mfb_splitter.sv
test/tb_mfb_splitter.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the splitter testbench with Verilator, runs it and checks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mfb_splitter \
    -f mfb_splitter.f -o sim_mfb_splitter \
    || { echo "build failed"; exit 1; }

out="$(./obj_dir/sim_mfb_splitter)"
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1
